// File: design/cache_rd_config.svh
`ifndef CACHE_RD_CONFIG_SVH
`define CACHE_RD_CONFIG_SVH

// accessor address width in bits
`define CACHE_ADDR_W 32

// width of one data word
`define CACHE_DATA_W 32

// lines held by the slice
`define CACHE_WAYS 4

// words in one cache line
`define CACHE_LINE_WORDS 32

`endif

// File: design/cache_rd_pkg.sv
`include "cache_rd_config.svh"

package cache_rd_pkg;

    localparam int TAG_W  = $clog2(`CACHE_WAYS);
    localparam int WORD_W = $clog2(`CACHE_LINE_WORDS);
    localparam int BYTE_W = 2;
    localparam int LINE_W = `CACHE_ADDR_W - WORD_W - BYTE_W;

    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        logic [LINE_W-1:0] line;
        logic [WORD_W-1:0] word;
        logic [BYTE_W-1:0] byte_off;
    } cache_addr_fields_t;

    // one address word, seen raw or split into line, word and byte
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        cache_addr_fields_t       fields;
    } cache_addr_u;

    typedef struct packed {
        tag_t              tag;
        logic [WORD_W-1:0] word;
    } mem_addr_t;

    // lookup replies and allocate replies share the status field
    typedef enum logic [2:0] {
        DIR_MISS         = 3'b000,
        DIR_HIT_CLEAN    = 3'b001,
        DIR_HIT_DIRTY    = 3'b010,
        DIR_HIT_SHARED   = 3'b011,
        DIR_HIT_OWNED    = 3'b110,
        DIR_VICTIM_CLEAN = 3'b101,
        DIR_VICTIM_DIRTY = 3'b111
    } dir_status_e;

    typedef enum logic [2:0] {
        DIR_LOOKUP    = 3'b001,
        DIR_ALLOCATE  = 3'b010,
        DIR_FILL_DONE = 3'b011
    } dir_cmd_e;

    typedef enum logic [1:0] {
        FETCH_WRITEBACK = 2'b00,
        FETCH_FILL      = 2'b01
    } fetch_cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        NORM,
        WAIT_LOOKUP,
        WAIT_MEM,
        ALLOCATE_LINE,
        WB_REQ,
        WAIT_WB_DONE,
        FILL_REQ,
        WAIT_FILL_DONE,
        ACC_MEM,
        UPDATE_LIST,
        UPDATE_DONE
    } rd_state_e;

    typedef struct packed {
        dir_cmd_e                 cmd;
        logic [`CACHE_ADDR_W-1:0] index;
        tag_t                     tag;
    } dir_req_t;

    typedef struct packed {
        dir_status_e              status;
        tag_t                     tag;
        logic [`CACHE_ADDR_W-1:0] victim_index;
    } dir_rsp_t;

    typedef struct packed {
        fetch_cmd_e               cmd;
        tag_t                     tag;
        logic [`CACHE_ADDR_W-1:0] addr;
    } fetch_req_t;

endpackage

// File: design/cache_rd_fsm.sv
`timescale 1ns/1ps
`include "cache_rd_config.svh"

module cache_rd_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_valid_i,
    input  cache_rd_pkg::cache_addr_u rd_addr_i,
    input  logic                      hold_full_i,
    input  logic                      dir_hsk_i,
    input  cache_rd_pkg::dir_rsp_t    dir_rsp_i,
    input  logic                      fetch_ready_i,
    input  logic                      fetch_done_i,
    input  logic                      mem_hsk_i,
    input  cache_rd_pkg::tag_t        tag_q_i,
    output logic                      rd_ready_o,
    output cache_rd_pkg::rd_state_e   state_o,
    output cache_rd_pkg::cache_addr_u line_addr_o,
    output logic                      fetch_valid_o,
    output cache_rd_pkg::fetch_req_t  fetch_req_o
);
    import cache_rd_pkg::*;

    rd_state_e                state_q;
    rd_state_e                state_d;
    rd_state_e                lookup_ns;
    cache_addr_u              addr_q;
    cache_addr_u              fill_addr;
    logic [`CACHE_ADDR_W-1:0] victim_q;
    logic                     wb_pending_q;
    logic                     rd_hsk;
    logic                     fetch_hsk;

    assign state_o    = state_q;
    assign rd_ready_o = (state_q == IDLE || state_q == NORM) && !hold_full_i;
    assign rd_hsk     = rd_valid_i && rd_ready_o;
    assign fetch_hsk  = fetch_valid_o && fetch_ready_i;

    // address of the request in service, live in its accept cycle
    assign line_addr_o = rd_hsk ? rd_addr_i : addr_q;

    always_ff @(posedge clk) begin
        if (rd_hsk) begin
            addr_q <= rd_addr_i;
        end
        if (state_q == ALLOCATE_LINE && dir_hsk_i) begin
            victim_q <= dir_rsp_i.victim_index;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_pending_q <= 1'b0;
        end else if (state_q == ALLOCATE_LINE && dir_hsk_i) begin
            wb_pending_q <= (dir_rsp_i.status == DIR_VICTIM_DIRTY);
        end else if (state_q == WAIT_WB_DONE && fetch_done_i) begin
            wb_pending_q <= 1'b0;
        end
    end

    // outcome of a lookup, shared by the accepting states
    always_comb begin
        if (!dir_hsk_i) begin
            lookup_ns = WAIT_LOOKUP;
        end else if (dir_rsp_i.status == DIR_MISS) begin
            lookup_ns = ALLOCATE_LINE;
        end else if (!mem_hsk_i) begin
            lookup_ns = WAIT_MEM;
        end else begin
            lookup_ns = NORM;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:           state_d = rd_hsk ? lookup_ns : IDLE;
            NORM:           state_d = rd_hsk ? lookup_ns : IDLE;
            WAIT_LOOKUP:    state_d = lookup_ns;
            WAIT_MEM:       state_d = mem_hsk_i ? NORM : WAIT_MEM;
            ALLOCATE_LINE: begin
                if (dir_hsk_i) begin
                    state_d = (dir_rsp_i.status == DIR_VICTIM_DIRTY) ? WB_REQ : FILL_REQ;
                end
            end
            WB_REQ:         state_d = fetch_hsk ? WAIT_WB_DONE : WB_REQ;
            WAIT_WB_DONE:   state_d = fetch_done_i ? FILL_REQ : WAIT_WB_DONE;
            FILL_REQ:       state_d = fetch_hsk ? WAIT_FILL_DONE : FILL_REQ;
            WAIT_FILL_DONE: state_d = fetch_done_i ? ACC_MEM : WAIT_FILL_DONE;
            ACC_MEM:        state_d = mem_hsk_i ? UPDATE_LIST : ACC_MEM;
            UPDATE_LIST:    state_d = dir_hsk_i ? UPDATE_DONE : UPDATE_LIST;
            UPDATE_DONE:    state_d = NORM;
            default:        state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // fill goes to the line base of the held request
    always_comb begin
        fill_addr = addr_q;
        fill_addr.fields.word = '0;
        fill_addr.fields.byte_off = '0;
    end

    assign fetch_valid_o = (state_q == WB_REQ) || (state_q == FILL_REQ);

    always_comb begin
        fetch_req_o.tag = tag_q_i;
        if (wb_pending_q) begin
            fetch_req_o.cmd  = FETCH_WRITEBACK;
            fetch_req_o.addr = victim_q;
        end else begin
            fetch_req_o.cmd  = FETCH_FILL;
            fetch_req_o.addr = fill_addr.raw;
        end
    end

    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid_o && !fetch_ready_i |=> fetch_valid_o && $stable(fetch_req_o))
        else $error("fetch request dropped or changed before grant");

endmodule

// File: design/cache_dir_req.sv
`timescale 1ns/1ps

module cache_dir_req (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cache_rd_pkg::rd_state_e   state_i,
    input  logic                      rd_hsk_i,
    input  cache_rd_pkg::cache_addr_u line_addr_i,
    input  logic                      dir_req_ready_i,
    input  cache_rd_pkg::dir_rsp_t    dir_rsp_i,
    output logic                      dir_req_valid_o,
    output cache_rd_pkg::dir_req_t    dir_req_o,
    output logic                      dir_hsk_o,
    output cache_rd_pkg::tag_t        tag_q_o
);
    import cache_rd_pkg::*;

    cache_addr_u line_idx;

    always_comb begin
        line_idx = line_addr_i;
        line_idx.fields.word = '0;
        line_idx.fields.byte_off = '0;
    end

    always_comb begin
        dir_req_valid_o = 1'b0;
        dir_req_o.cmd   = DIR_LOOKUP;
        dir_req_o.index = line_idx.raw;
        dir_req_o.tag   = '0;
        if (rd_hsk_i || state_i == WAIT_LOOKUP) begin
            dir_req_valid_o = 1'b1;
        end else if (state_i == ALLOCATE_LINE) begin
            dir_req_valid_o = 1'b1;
            dir_req_o.cmd   = DIR_ALLOCATE;
        end else if (state_i == UPDATE_LIST) begin
            // fill complete on the allocated way
            dir_req_valid_o = 1'b1;
            dir_req_o.cmd   = DIR_FILL_DONE;
            dir_req_o.tag   = tag_q_o;
        end
    end

    assign dir_hsk_o = dir_req_valid_o && dir_req_ready_i;

    always_ff @(posedge clk) begin
        if (dir_hsk_o && dir_req_o.cmd != DIR_FILL_DONE) begin
            tag_q_o <= dir_rsp_i.tag;
        end
    end

    a_alloc_victim: assert property (@(posedge clk) disable iff (!rst_n)
        dir_hsk_o && dir_req_o.cmd == DIR_ALLOCATE |->
            dir_rsp_i.status inside {DIR_VICTIM_CLEAN, DIR_VICTIM_DIRTY})
        else $error("allocate reply carries no victim status");

endmodule

// File: design/cache_mem_rd.sv
`timescale 1ns/1ps

module cache_mem_rd (
    input  cache_rd_pkg::rd_state_e   state_i,
    input  logic                      dir_hsk_i,
    input  cache_rd_pkg::dir_rsp_t    dir_rsp_i,
    input  cache_rd_pkg::tag_t        tag_q_i,
    input  cache_rd_pkg::cache_addr_u rd_addr_i,
    input  logic                      hold_full_i,
    input  logic                      mem_rready_i,
    output logic                      mem_ren_o,
    output cache_rd_pkg::mem_addr_t   mem_raddr_o,
    output logic                      mem_hsk_o
);
    import cache_rd_pkg::*;

    logic lookup_hit;

    // only lookups are granted in these states
    assign lookup_hit = dir_hsk_i && dir_rsp_i.status != DIR_MISS &&
                        (state_i == IDLE || state_i == NORM || state_i == WAIT_LOOKUP);

    always_comb begin
        mem_ren_o        = 1'b0;
        mem_raddr_o.tag  = tag_q_i;
        mem_raddr_o.word = rd_addr_i.fields.word;
        if (!hold_full_i) begin
            if (lookup_hit) begin
                // tag not yet registered in the grant cycle
                mem_ren_o       = 1'b1;
                mem_raddr_o.tag = dir_rsp_i.tag;
            end else if (state_i == WAIT_MEM || state_i == ACC_MEM) begin
                mem_ren_o = 1'b1;
            end
        end
    end

    assign mem_hsk_o = mem_ren_o && mem_rready_i;

    always_comb begin
        a_no_grant_held: assert final
            (!(dir_hsk_i && (state_i == WAIT_MEM || state_i == ACC_MEM)))
            else $error("directory granted while a read waits on the held tag");
    end

endmodule

// File: design/cache_rd_resp.sv
`timescale 1ns/1ps
`include "cache_rd_config.svh"

module cache_rd_resp (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mem_rdata_valid_i,
    input  logic [`CACHE_DATA_W-1:0] mem_rdata_i,
    input  logic                     mem_hsk_i,
    input  logic                     rd_data_ready_i,
    output logic                     rd_data_valid_o,
    output logic [`CACHE_DATA_W-1:0] rd_data_o,
    output logic                     rd_done_o,
    output logic                     hold_full_o
);
    logic                     hold_valid_q;
    logic [`CACHE_DATA_W-1:0] hold_data_q;
    logic                     hold_load;

    // held word goes out first
    assign rd_data_valid_o = hold_valid_q || mem_rdata_valid_i;
    assign rd_data_o       = hold_valid_q ? hold_data_q : mem_rdata_i;
    assign hold_full_o     = rd_data_valid_o && !rd_data_ready_i;

    // memory word not taken this cycle
    assign hold_load = mem_rdata_valid_i && (hold_valid_q || !rd_data_ready_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid_q <= 1'b0;
            rd_done_o    <= 1'b0;
        end else begin
            rd_done_o <= mem_hsk_i;
            if (hold_load) begin
                hold_valid_q <= 1'b1;
            end else if (rd_data_ready_i) begin
                hold_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold_load) begin
            hold_data_q <= mem_rdata_i;
        end
    end

    a_hold_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        hold_valid_q && !rd_data_ready_i |-> !mem_rdata_valid_i)
        else $error("read word arrived while hold buffer is full");

endmodule

// File: design/cache_rd_ctrl.sv
`timescale 1ns/1ps
`include "cache_rd_config.svh"

module cache_rd_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      rd_valid_i,
    output logic                      rd_ready_o,
    input  cache_rd_pkg::cache_addr_u rd_addr_i,
    output logic                      rd_data_valid_o,
    input  logic                      rd_data_ready_i,
    output logic [`CACHE_DATA_W-1:0]  rd_data_o,
    output logic                      rd_done_o,

    output logic                      dir_req_valid_o,
    input  logic                      dir_req_ready_i,
    output cache_rd_pkg::dir_req_t    dir_req_o,
    input  cache_rd_pkg::dir_rsp_t    dir_rsp_i,

    output logic                      fetch_valid_o,
    input  logic                      fetch_ready_i,
    output cache_rd_pkg::fetch_req_t  fetch_req_o,
    input  logic                      fetch_done_i,

    output logic                      mem_ren_o,
    input  logic                      mem_rready_i,
    output cache_rd_pkg::mem_addr_t   mem_raddr_o,
    input  logic                      mem_rdata_valid_i,
    input  logic [`CACHE_DATA_W-1:0]  mem_rdata_i
);
    import cache_rd_pkg::*;

    rd_state_e   state;
    cache_addr_u line_addr;
    tag_t        tag_q;
    logic        rd_hsk;
    logic        dir_hsk;
    logic        mem_hsk;
    logic        hold_full;

    assign rd_hsk = rd_valid_i && rd_ready_o;

    cache_rd_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid_i    (rd_valid_i),
        .rd_addr_i     (rd_addr_i),
        .hold_full_i   (hold_full),
        .dir_hsk_i     (dir_hsk),
        .dir_rsp_i     (dir_rsp_i),
        .fetch_ready_i (fetch_ready_i),
        .fetch_done_i  (fetch_done_i),
        .mem_hsk_i     (mem_hsk),
        .tag_q_i       (tag_q),
        .rd_ready_o    (rd_ready_o),
        .state_o       (state),
        .line_addr_o   (line_addr),
        .fetch_valid_o (fetch_valid_o),
        .fetch_req_o   (fetch_req_o)
    );

    cache_dir_req u_dir_req (
        .clk             (clk),
        .rst_n           (rst_n),
        .state_i         (state),
        .rd_hsk_i        (rd_hsk),
        .line_addr_i     (line_addr),
        .dir_req_ready_i (dir_req_ready_i),
        .dir_rsp_i       (dir_rsp_i),
        .dir_req_valid_o (dir_req_valid_o),
        .dir_req_o       (dir_req_o),
        .dir_hsk_o       (dir_hsk),
        .tag_q_o         (tag_q)
    );

    cache_mem_rd u_mem_rd (
        .state_i      (state),
        .dir_hsk_i    (dir_hsk),
        .dir_rsp_i    (dir_rsp_i),
        .tag_q_i      (tag_q),
        .rd_addr_i    (line_addr),
        .hold_full_i  (hold_full),
        .mem_rready_i (mem_rready_i),
        .mem_ren_o    (mem_ren_o),
        .mem_raddr_o  (mem_raddr_o),
        .mem_hsk_o    (mem_hsk)
    );

    cache_rd_resp u_rd_resp (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_rdata_valid_i (mem_rdata_valid_i),
        .mem_rdata_i       (mem_rdata_i),
        .mem_hsk_i         (mem_hsk),
        .rd_data_ready_i   (rd_data_ready_i),
        .rd_data_valid_o   (rd_data_valid_o),
        .rd_data_o         (rd_data_o),
        .rd_done_o         (rd_done_o),
        .hold_full_o       (hold_full)
    );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset held for five rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: dv/tb_cache_rd_ctrl.sv
`timescale 1ns/1ps
`include "cache_rd_config.svh"

module tb_cache_rd_ctrl;
    import cache_rd_pkg::*;

    localparam int TIMEOUT_CYCLES = 300 * 80;

    typedef logic [`CACHE_DATA_W-1:0] word_t;

    logic        clk;
    logic        rst_n;
    logic        rd_valid;
    logic        rd_ready;
    cache_addr_u rd_addr;
    logic        rd_data_valid;
    logic        rd_data_ready;
    word_t       rd_data;
    logic        rd_done;
    logic        dir_req_valid;
    logic        dir_req_ready;
    dir_req_t    dir_req;
    dir_rsp_t    dir_rsp;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_req_t  fetch_req;
    logic        fetch_done;
    logic        mem_ren;
    logic        mem_rready;
    mem_addr_t   mem_raddr;
    logic        mem_rdata_valid;
    word_t       mem_rdata;

    // directory contents with one line per way
    logic [LINE_W-1:0] way_line [`CACHE_WAYS];
    word_t             exp_q [$];
    fetch_req_t        fetch_q [$];
    word_t             mem_q [$];
    int                mem_due [$];
    int    cycle = 0;
    int    buf_words;
    int    fetch_timer;
    int    reads;
    int    done_count;
    int    fill_count;
    int    wb_count;
    int    errors = 0;
    int    checks = 0;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    logic  stall_en;
    string test_name = "startup";

    tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    cache_rd_ctrl dut0 (
        .clk(clk), .rst_n(rst_n),
        .rd_valid_i(rd_valid), .rd_ready_o(rd_ready), .rd_addr_i(rd_addr),
        .rd_data_valid_o(rd_data_valid), .rd_data_ready_i(rd_data_ready),
        .rd_data_o(rd_data), .rd_done_o(rd_done),
        .dir_req_valid_o(dir_req_valid), .dir_req_ready_i(dir_req_ready),
        .dir_req_o(dir_req), .dir_rsp_i(dir_rsp),
        .fetch_valid_o(fetch_valid), .fetch_ready_i(fetch_ready),
        .fetch_req_o(fetch_req), .fetch_done_i(fetch_done),
        .mem_ren_o(mem_ren), .mem_rready_i(mem_rready), .mem_raddr_o(mem_raddr),
        .mem_rdata_valid_i(mem_rdata_valid), .mem_rdata_i(mem_rdata)
    );

    // memory holds line number xor word offset
    function automatic word_t ref_word(cache_addr_u a);
        return word_t'(a.fields.line) ^ word_t'(a.fields.word);
    endfunction

    function automatic dir_status_e hit_status(logic [LINE_W-1:0] line);
        case (line[1:0])
            2'd0:    return DIR_HIT_CLEAN;
            2'd1:    return DIR_HIT_DIRTY;
            2'd2:    return DIR_HIT_SHARED;
            default: return DIR_HIT_OWNED;
        endcase
    endfunction

    function automatic logic [`CACHE_ADDR_W-1:0] line_base(logic [LINE_W-1:0] line);
        cache_addr_u a;
        a.raw = '0;
        a.fields.line = line;
        return a.raw;
    endfunction

    function automatic cache_addr_u make_addr(int line, int word);
        cache_addr_u a;
        a.fields.line = line;
        a.fields.word = word;
        a.fields.byte_off = $urandom % 4;
        return a;
    endfunction

    task automatic check_value(string label, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h",
                     test_name, label, expected, actual);
        end
    endtask

    task automatic flag_error(string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // directory replies in the cycle of the request
    always_comb begin
        cache_addr_u idx;
        tag_t        way;
        idx = dir_req.index;
        way = tag_t'(idx.fields.line % `CACHE_WAYS);
        dir_rsp.status       = DIR_MISS;
        dir_rsp.tag          = way;
        dir_rsp.victim_index = '0;
        if (dir_req.cmd == DIR_LOOKUP) begin
            if (way_line[way] == idx.fields.line) begin
                dir_rsp.status = hit_status(idx.fields.line);
            end
        end else if (dir_req.cmd == DIR_ALLOCATE) begin
            dir_rsp.victim_index = line_base(way_line[way]);
            dir_rsp.status = way_line[way][0] ? DIR_VICTIM_DIRTY : DIR_VICTIM_CLEAN;
        end
    end

    // directory, fetch and memory models
    always @(posedge clk) begin
        cache_addr_u idx;
        tag_t        way;
        mem_addr_t   ra;
        logic        next_ready;
        if (rst_n) begin
            idx = dir_req.index;
            way = tag_t'(idx.fields.line % `CACHE_WAYS);
            dir_req_ready <= ($urandom % 4) != 0;
            if (dir_req_valid && dir_req_ready) begin
                if (dir_req.cmd == DIR_ALLOCATE) begin
                    // odd victim lines are dirty
                    if (way_line[way][0]) begin
                        fetch_q.push_back(fetch_req_t'{cmd: FETCH_WRITEBACK, tag: way,
                                                       addr: line_base(way_line[way])});
                    end
                    fetch_q.push_back(fetch_req_t'{cmd: FETCH_FILL, tag: way,
                                                   addr: line_base(idx.fields.line)});
                    way_line[way] <= idx.fields.line;
                end else if (dir_req.cmd == DIR_FILL_DONE) begin
                    check_value("fill done way", way, dir_req.tag);
                end
            end

            fetch_done <= 1'b0;
            if (fetch_timer > 0) begin
                fetch_timer--;
                if (fetch_timer == 0) begin
                    fetch_done <= 1'b1;
                end
            end
            fetch_ready <= $urandom % 2;
            if (fetch_valid && fetch_ready) begin
                if (fetch_q.size() == 0) begin
                    flag_error("fetch request seen with no allocation pending");
                end else begin
                    check_value("fetch request", fetch_q.pop_front(), fetch_req);
                end
                if (fetch_req.cmd == FETCH_FILL) begin
                    fill_count++;
                end else begin
                    wb_count++;
                end
                fetch_timer = 1 + $urandom % 5;
            end

            mem_rready <= ($urandom % 4) != 0;
            if (mem_ren && mem_rready) begin
                if (fetch_q.size() != 0 || fetch_timer > 0) begin
                    flag_error("memory read issued before the line fill completed");
                end
                ra = mem_raddr;
                mem_q.push_back(word_t'(way_line[ra.tag]) ^ word_t'(ra.word));
                mem_due.push_back(cycle + 1 + $urandom % 4);
            end

            // words sitting in the DUT hold buffer
            buf_words = buf_words + int'(mem_rdata_valid) - int'(rd_data_valid && rd_data_ready);
            next_ready = !stall_en || ($urandom % 3 != 0);
            rd_data_ready <= next_ready;
            if (mem_q.size() != 0 && mem_due[0] <= cycle && (buf_words == 0 || next_ready)) begin
                mem_rdata_valid <= 1'b1;
                mem_rdata <= mem_q.pop_front();
                void'(mem_due.pop_front());
            end else begin
                mem_rdata_valid <= 1'b0;
            end
        end
    end

    // compare returned words in request order
    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_done) begin
                done_count++;
            end
            if (rd_data_valid && rd_data_ready) begin
                if (exp_q.size() == 0) begin
                    flag_error("read data returned with no read outstanding");
                end else begin
                    check_value("read data", exp_q.pop_front(), rd_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles in test %s", cycle, test_name);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic send_read(cache_addr_u a);
        rd_valid <= 1'b1;
        rd_addr  <= a;
        do @(posedge clk); while (!rd_ready);
        exp_q.push_back(ref_word(a));
        reads++;
    endtask

    task automatic run_reads(int n, int lines);
        repeat (n) begin
            send_read(make_addr($urandom % lines, $urandom % `CACHE_LINE_WORDS));
            if ($urandom % 4 == 0) begin
                rd_valid <= 1'b0;
                @(posedge clk);
            end
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        errors_at_start = errors;
        reads = 0;
        done_count = 0;
        fill_count = 0;
        wb_count = 0;
    endtask

    // negative counts skip the fetch count checks
    task automatic end_test(int fills, int wbs);
        rd_valid <= 1'b0;
        stall_en <= 1'b0;
        do @(posedge clk); while (exp_q.size() != 0 || !rd_ready);
        repeat (3) @(posedge clk);
        check_value("done pulses", reads, done_count);
        if (fills >= 0) begin
            check_value("fill requests", fills, fill_count);
        end
        if (wbs >= 0) begin
            check_value("write-back requests", wbs, wb_count);
        end
        if (fetch_q.size() != 0) begin
            flag_error("an expected fetch request never arrived");
        end
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s finished, %0d reads, clean", test_name, reads);
        end else begin
            tests_failed++;
            $display("test %s finished, %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        void'($urandom(32'h1bf4_efad));
        rd_valid = 1'b0;
        rd_addr = '0;
        rd_data_ready = 1'b1;
        dir_req_ready = 1'b0;
        fetch_ready = 1'b0;
        fetch_done = 1'b0;
        mem_rready = 1'b0;
        mem_rdata_valid = 1'b0;
        mem_rdata = '0;
        stall_en = 1'b0;
        buf_words = 0;
        fetch_timer = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_line[w] = w;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);

        start_test("reset_idle");
        repeat (4) begin
            @(posedge clk);
            check_value("rd_ready_o", 1, rd_ready);
            check_value("idle outputs", 0, {rd_data_valid, dir_req_valid, fetch_valid, mem_ren});
        end
        end_test(0, 0);

        start_test("resident_hits");
        run_reads(60, `CACHE_WAYS);
        end_test(0, 0);

        // line 8 replaces even line 0
        start_test("clean_miss");
        send_read(make_addr(8, 5));
        send_read(make_addr(8, 9));
        end_test(1, 0);

        // line 9 replaces odd line 1
        start_test("dirty_miss");
        send_read(make_addr(9, 17));
        end_test(1, 1);

        start_test("stalled_reads");
        stall_en <= 1'b1;
        run_reads(200, 12);
        end_test(-1, -1);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: cache_rd_ctrl.f
+incdir+design
design/cache_rd_pkg.sv
design/cache_rd_fsm.sv
design/cache_dir_req.sv
design/cache_mem_rd.sv
design/cache_rd_resp.sv
design/cache_rd_ctrl.sv
dv/tb_clk_gen.sv
dv/tb_cache_rd_ctrl.sv

// File: Bender.yml
package:
  name: cache_rd_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/cache_rd_pkg.sv
      - design/cache_rd_fsm.sv
      - design/cache_dir_req.sv
      - design/cache_mem_rd.sv
      - design/cache_rd_resp.sv
      - design/cache_rd_ctrl.sv
      - target: test
        files:
          - dv/tb_clk_gen.sv
          - dv/tb_cache_rd_ctrl.sv
